/* pic_pkg.sv */
// Shared widths, file addresses, enums and the instruction decoder of the core
// Imported by every block of the design
`default_nettype none

package pic_pkg;

   localparam int data_w      = 8;
   localparam int pc_w        = 13;
   localparam int op_w        = 14;
   localparam int fa_w        = 7;
   localparam int porta_w     = 5;
   localparam int portb_w     = 8;
   localparam int stack_depth = 8;

   // File addresses, bank 1 reuses the port offsets for TRIS
   localparam logic [fa_w-1:0] addr_status = 7'h03;
   localparam logic [fa_w-1:0] addr_porta  = 7'h05;
   localparam logic [fa_w-1:0] addr_portb  = 7'h06;
   localparam logic [fa_w-1:0] ram_lo      = 7'h0C;
   localparam logic [fa_w-1:0] ram_hi      = 7'h4F;

   // STATUS bit positions
   localparam int c_bit   = 0;
   localparam int dc_bit  = 1;
   localparam int z_bit   = 2;
   localparam int rp0_bit = 5;

   typedef enum logic [4:0] {
      op_nop,   op_addwf, op_subwf,  op_andwf,  op_iorwf, op_xorwf,
      op_comf,  op_decf,  op_incf,   op_movf,   op_movwf, op_clr,
      op_rlf,   op_rrf,   op_swapf,  op_decfsz, op_incfsz,
      op_bcf,   op_bsf,   op_btfsc,  op_btfss,
      op_addlw, op_sublw, op_andlw,  op_iorlw,  op_xorlw, op_movlw,
      op_retlw, op_goto,  op_call,   op_return
   } opcode_e;

   typedef enum logic [1:0] {q1, q2, q3, q4} phase_e;

   typedef enum logic [2:0] {pc_inc, pc_hold, pc_jump, pc_call, pc_ret} pc_action_e;

   typedef struct packed {
      opcode_e             op;
      logic                dest;      // 0 = W, 1 = file
      logic [fa_w-1:0]     fa;
      logic [2:0]          bit_idx;
      logic [data_w-1:0]   lit;
      logic [10:0]         jump;
   } decoded_t;

   typedef struct packed {
      logic c;
      logic dc;
      logic z;
   } flags_t;

   // Field extraction is shared, only the opcode depends on the pattern
   function automatic decoded_t decode_op(input logic [op_w-1:0] code);
      decoded_t d;
      d.dest    = code[7];
      d.fa      = code[6:0];
      d.bit_idx = code[9:7];
      d.lit     = code[7:0];
      d.jump    = code[10:0];
      casez (code)
         14'b00_0111_????_???? : d.op = op_addwf;
         14'b00_0010_????_???? : d.op = op_subwf;
         14'b00_0101_????_???? : d.op = op_andwf;
         14'b00_0100_????_???? : d.op = op_iorwf;
         14'b00_0110_????_???? : d.op = op_xorwf;
         14'b00_1001_????_???? : d.op = op_comf;
         14'b00_0011_????_???? : d.op = op_decf;
         14'b00_1010_????_???? : d.op = op_incf;
         14'b00_1000_????_???? : d.op = op_movf;
         14'b00_0000_1???_???? : d.op = op_movwf;
         14'b00_0001_????_???? : d.op = op_clr;      // CLRF and CLRW
         14'b00_1101_????_???? : d.op = op_rlf;
         14'b00_1100_????_???? : d.op = op_rrf;
         14'b00_1110_????_???? : d.op = op_swapf;
         14'b00_1011_????_???? : d.op = op_decfsz;
         14'b00_1111_????_???? : d.op = op_incfsz;
         14'b00_0000_0000_1000 : d.op = op_return;
         14'b01_00??_????_???? : d.op = op_bcf;
         14'b01_01??_????_???? : d.op = op_bsf;
         14'b01_10??_????_???? : d.op = op_btfsc;
         14'b01_11??_????_???? : d.op = op_btfss;
         14'b10_0???_????_???? : d.op = op_call;
         14'b10_1???_????_???? : d.op = op_goto;
         14'b11_00??_????_???? : d.op = op_movlw;
         14'b11_01??_????_???? : d.op = op_retlw;
         14'b11_1000_????_???? : d.op = op_iorlw;
         14'b11_1001_????_???? : d.op = op_andlw;
         14'b11_1010_????_???? : d.op = op_xorlw;
         14'b11_110?_????_???? : d.op = op_sublw;
         14'b11_111?_????_???? : d.op = op_addlw;
         default               : d.op = op_nop;    // NOP and anything unsupported
      endcase
      return d;
   endfunction

endpackage

`default_nettype wire

/* file_bus_if.sv */
// File register bus between the sequencer and the register file
// Reads are combinational, writes land on the edge ending Q4
`default_nettype none

interface file_bus_if;
   import pic_pkg::*;

   logic [fa_w-1:0]   addr;
   logic [data_w-1:0] wr_data;
   logic              wr_en;
   flags_t            flag_we;     // Per-flag update enable
   flags_t            flags_new;
   logic [data_w-1:0] rd_data;
   logic              carry;       // Current STATUS C

   modport seq (
      output addr, wr_data, wr_en, flag_we, flags_new,
      input  rd_data, carry
   );

   modport regs (
      input  addr, wr_data, wr_en, flag_we, flags_new,
      output rd_data, carry
   );

endinterface

`default_nettype wire

/* pic_alu_if.sv */
// Operand and result bundle between the sequencer and the ALU
`default_nettype none

interface pic_alu_if;
   import pic_pkg::*;

   opcode_e           op;
   logic [data_w-1:0] w;
   logic [data_w-1:0] f;
   logic [data_w-1:0] k;
   logic [2:0]        bit_idx;
   logic              carry_in;
   logic [data_w-1:0] result;
   flags_t            flags_out;

   modport seq (
      output op, w, f, k, bit_idx, carry_in,
      input  result, flags_out
   );

   modport alu (
      input  op, w, f, k, bit_idx, carry_in,
      output result, flags_out
   );

endinterface

`default_nettype wire

/* pic_alu.sv */
// Combinational data path for all byte, bit and literal operations
`default_nettype none

module pic_alu (
   pic_alu_if.alu au
);
   import pic_pkg::*;

   logic [data_w-1:0] mask;
   logic [data_w-1:0] x;
   logic [data_w-1:0] y;
   logic              sub;
   logic [data_w:0]   sum;
   logic [4:0]        nib;

   always_comb begin
      mask = data_w'(1) << au.bit_idx;
      sub  = (au.op == op_subwf) || (au.op == op_sublw);
      x    = (au.op == op_addlw || au.op == op_sublw) ? au.k : au.f;
      y    = sub ? ~au.w : au.w;                    // Two's complement subtract
      sum  = {1'b0, x} + {1'b0, y} + (data_w + 1)'(sub);
      nib  = {1'b0, x[3:0]} + {1'b0, y[3:0]} + 5'(sub);

      au.result       = '0;
      au.flags_out.c  = 1'b0;
      au.flags_out.dc = 1'b0;
      case (au.op)
         op_addwf, op_subwf, op_addlw, op_sublw: begin
            au.result       = sum[data_w-1:0];
            au.flags_out.c  = sum[data_w];            // No borrow when subtracting
            au.flags_out.dc = nib[4];
         end
         op_andwf:             au.result = au.w & au.f;
         op_andlw:             au.result = au.w & au.k;
         op_iorwf:             au.result = au.w | au.f;
         op_iorlw:             au.result = au.w | au.k;
         op_xorwf:             au.result = au.w ^ au.f;
         op_xorlw:             au.result = au.w ^ au.k;
         op_comf:              au.result = ~au.f;
         op_decf, op_decfsz:   au.result = au.f - 1'b1;
         op_incf, op_incfsz:   au.result = au.f + 1'b1;
         op_movf:              au.result = au.f;
         op_movwf:             au.result = au.w;
         op_rlf: begin
            au.result      = {au.f[data_w-2:0], au.carry_in};
            au.flags_out.c = au.f[data_w-1];
         end
         op_rrf: begin
            au.result      = {au.carry_in, au.f[data_w-1:1]};
            au.flags_out.c = au.f[0];
         end
         op_swapf:             au.result = {au.f[3:0], au.f[7:4]};
         op_bcf:               au.result = au.f & ~mask;
         op_bsf:               au.result = au.f | mask;
         op_btfsc, op_btfss:   au.result = au.f & mask;   // Zero when bit clear
         op_movlw, op_retlw:   au.result = au.k;
         default: ;                                       // CLR and control ops give 0
      endcase
      au.flags_out.z = (au.result == '0);
   end

endmodule

`default_nettype wire

/* pic_file_regs.sv */
// Banked file registers: STATUS, shared RAM, port latches and TRIS
// RP0 selects PORTx in bank 0 and TRISx in bank 1
`default_nettype none

module pic_file_regs (
   input  logic                        clk,
   input  logic                        arst_n,
   file_bus_if.regs                    fb,
   input  logic [pic_pkg::porta_w-1:0] port_a_data_in,
   input  logic [pic_pkg::portb_w-1:0] port_b_data_in,
   output logic [pic_pkg::porta_w-1:0] port_a_tris,
   output logic [pic_pkg::porta_w-1:0] port_a_data_out,
   output logic [pic_pkg::portb_w-1:0] port_b_tris,
   output logic [pic_pkg::portb_w-1:0] port_b_data_out,
   output logic                        z
);
   import pic_pkg::*;

   logic              c_q;
   logic              dc_q;
   logic              z_q;
   logic              rp0_q;
   logic [data_w-1:0] ram [ram_lo:ram_hi];
   logic [porta_w-1:0] pin_a_q;
   logic [porta_w-1:0] lat_a_q;
   logic [porta_w-1:0] tris_a_q;
   logic [portb_w-1:0] pin_b_q;
   logic [portb_w-1:0] lat_b_q;
   logic [portb_w-1:0] tris_b_q;
   logic              sel_status;
   logic              sel_ram;
   logic              sel_a;
   logic              sel_b;
   logic [data_w-1:0] status_rd;

   // ==================================================
   // Address decode and read mux
   // ==================================================
   assign sel_status = (fb.addr == addr_status);
   assign sel_ram    = (fb.addr >= ram_lo) && (fb.addr <= ram_hi);   // Same in both banks
   assign sel_a      = (fb.addr == addr_porta);
   assign sel_b      = (fb.addr == addr_portb);

   always_comb begin
      status_rd          = '0;                   // TO, PD and unused bits read 0
      status_rd[c_bit]   = c_q;
      status_rd[dc_bit]  = dc_q;
      status_rd[z_bit]   = z_q;
      status_rd[rp0_bit] = rp0_q;

      fb.rd_data = '0;
      if (sel_status) fb.rd_data = status_rd;
      else if (sel_ram) fb.rd_data = ram[fb.addr];
      else if (sel_a && rp0_q) fb.rd_data = data_w'(tris_a_q);
      else if (sel_a) fb.rd_data = data_w'((pin_a_q & tris_a_q) | (lat_a_q & ~tris_a_q));
      else if (sel_b && rp0_q) fb.rd_data = tris_b_q;
      else if (sel_b) fb.rd_data = (pin_b_q & tris_b_q) | (lat_b_q & ~tris_b_q);
   end

   // Pins sampled each clock, stable from Q1 through Q4
   always_ff @(posedge clk) begin
      pin_a_q <= port_a_data_in;
      pin_b_q <= port_b_data_in;
   end

   // ==================================================
   // Writes and flag updates at end of Q4
   // ==================================================
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         c_q      <= 1'b0;
         dc_q     <= 1'b0;
         z_q      <= 1'b0;
         rp0_q    <= 1'b0;
         lat_a_q  <= '0;
         lat_b_q  <= '0;
         tris_a_q <= '1;                          // All pins input
         tris_b_q <= '1;
         for (int i = ram_lo; i <= ram_hi; i++) ram[i] <= '0;
      end else begin
         if (fb.wr_en) begin
            if (sel_status) begin
               c_q   <= fb.wr_data[c_bit];
               dc_q  <= fb.wr_data[dc_bit];
               z_q   <= fb.wr_data[z_bit];
               rp0_q <= fb.wr_data[rp0_bit];
            end
            if (sel_ram) ram[fb.addr] <= fb.wr_data;
            if (sel_a && !rp0_q) lat_a_q  <= fb.wr_data[porta_w-1:0];
            if (sel_a && rp0_q)  tris_a_q <= fb.wr_data[porta_w-1:0];
            if (sel_b && !rp0_q) lat_b_q  <= fb.wr_data;
            if (sel_b && rp0_q)  tris_b_q <= fb.wr_data;
         end
         // Flag updates override a STATUS write
         if (fb.flag_we.c)  c_q  <= fb.flags_new.c;
         if (fb.flag_we.dc) dc_q <= fb.flags_new.dc;
         if (fb.flag_we.z)  z_q  <= fb.flags_new.z;
      end
   end

   assign fb.carry        = c_q;
   assign port_a_tris     = tris_a_q;
   assign port_a_data_out = lat_a_q;
   assign port_b_tris     = tris_b_q;
   assign port_b_data_out = lat_b_q;
   assign z               = z_q;

endmodule

`default_nettype wire

/* pic_pc_stack.sv */
// Program counter and 8-level circular return stack, updated at end of Q4
`default_nettype none

module pic_pc_stack (
   input  logic                     clk,
   input  logic                     arst_n,
   input  pic_pkg::phase_e          phase,
   input  pic_pkg::pc_action_e      pc_action,
   input  logic [10:0]              jump_target,
   output logic [pic_pkg::pc_w-1:0] pc_out
);
   import pic_pkg::*;

   logic [pc_w-1:0]                stack [stack_depth];
   logic [$clog2(stack_depth)-1:0] sp_q;
   logic [$clog2(stack_depth)-1:0] sp_prev;
   logic [pc_w-1:0]                target;

   assign target  = pc_w'(jump_target);           // Upper PC bits are zero
   assign sp_prev = sp_q - 1'b1;                  // Wraps 0 to 7

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc_out <= '0;
         sp_q   <= '0;
      end else if (phase == q4) begin
         case (pc_action)
            pc_inc:  pc_out <= pc_out + 1'b1;
            pc_jump: pc_out <= target;
            pc_call: begin
               pc_out <= target;
               sp_q   <= sp_q + 1'b1;              // Overflow overwrites oldest
            end
            pc_ret: begin
               pc_out <= stack[sp_prev];
               sp_q   <= sp_prev;
            end
            default: ;                              // Hold
         endcase
      end
   end

   // Return address push
   always_ff @(posedge clk) begin
      if (phase == q4 && pc_action == pc_call) stack[sp_q] <= pc_out + 1'b1;
   end

endmodule

`default_nettype wire

/* pic_sequencer.sv */
// Instruction cycle control: Q1..Q4 phases, instruction register, W and write-back
// Decides skips and branches and squashes the following cycle
`default_nettype none

module pic_sequencer (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [pic_pkg::op_w-1:0] op_code,
   file_bus_if.seq                  fb,
   pic_alu_if.seq                   au,
   output pic_pkg::phase_e          phase,
   output pic_pkg::pc_action_e      pc_action,
   output logic [10:0]              jump_target,
   output logic                     nop_out
);
   import pic_pkg::*;

   typedef enum logic [1:0] {sq_none, sq_skip, sq_branch} squash_e;

   decoded_t          ir;
   logic [data_w-1:0] w_q;
   logic [data_w-1:0] res_q;       // ALU result latched at end of Q3
   flags_t            flags_q;
   squash_e           sq_q;
   logic              execute;
   logic              to_file;
   logic              to_w;
   logic              skip;
   flags_t            fwe;
   pc_action_e        act;

   // ==================================================
   // Phase counter and cycle registers
   // ==================================================
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         phase <= q1;
         ir    <= '0;
         w_q   <= '0;
         sq_q  <= sq_none;
      end else begin
         phase <= phase_e'(phase + 2'd1);          // Q4 wraps to Q1
         if (phase == q1) ir <= decode_op(op_code);
         if (phase == q4) begin
            if (execute && to_w) w_q <= res_q;
            if (!execute) sq_q <= sq_none;         // Squash lasts one cycle
            else if (act != pc_inc) sq_q <= sq_branch;
            else if (skip) sq_q <= sq_skip;
            else sq_q <= sq_none;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (phase == q3) begin
         res_q   <= au.result;
         flags_q <= au.flags_out;
      end
   end

   // ==================================================
   // Per-opcode destination, flags and PC control
   // ==================================================
   always_comb begin
      to_file = 1'b0;
      to_w    = 1'b0;
      fwe     = '0;
      skip    = 1'b0;
      act     = pc_inc;
      case (ir.op)
         op_addwf, op_subwf, op_andwf, op_iorwf, op_xorwf, op_comf, op_decf, op_incf,
         op_movf, op_clr, op_rlf, op_rrf, op_swapf, op_decfsz, op_incfsz: begin
            to_file = ir.dest;
            to_w    = !ir.dest;
         end
         op_movwf, op_bcf, op_bsf:                     to_file = 1'b1;
         op_addlw, op_sublw, op_andlw, op_iorlw, op_xorlw, op_movlw: to_w = 1'b1;
         op_retlw: begin
            to_w = 1'b1;
            act  = pc_ret;
         end
         op_return: act = pc_ret;
         op_goto:   act = pc_jump;
         op_call:   act = pc_call;
         default: ;
      endcase

      case (ir.op)
         op_addwf, op_subwf, op_addlw, op_sublw: fwe = '{c: 1'b1, dc: 1'b1, z: 1'b1};
         op_rlf, op_rrf:                         fwe.c = 1'b1;
         op_andwf, op_iorwf, op_xorwf, op_comf, op_decf, op_incf, op_movf, op_clr,
         op_andlw, op_iorlw, op_xorlw:           fwe.z = 1'b1;
         default: ;
      endcase

      // Bit tests come back from the ALU as a masked value
      case (ir.op)
         op_decfsz, op_incfsz, op_btfsc: skip = flags_q.z;
         op_btfss:                       skip = !flags_q.z;
         default: ;
      endcase
   end

   assign execute = (sq_q == sq_none);

   assign fb.addr      = ir.fa;
   assign fb.wr_data   = res_q;
   assign fb.wr_en     = (phase == q4) && execute && to_file;
   assign fb.flag_we   = ((phase == q4) && execute) ? fwe : '0;
   assign fb.flags_new = flags_q;

   assign au.op       = ir.op;
   assign au.w        = w_q;
   assign au.f        = fb.rd_data;
   assign au.k        = ir.lit;
   assign au.bit_idx  = ir.bit_idx;
   assign au.carry_in = fb.carry;

   assign pc_action   = (sq_q == sq_skip)   ? pc_inc  :
                        (sq_q == sq_branch) ? pc_hold : act;
   assign jump_target = ir.jump;
   assign nop_out     = execute;

endmodule

`default_nettype wire

/* pic16_core.sv */
// Top level of the core, program ROM sits outside on pc_out / op_code
`default_nettype none

module pic16_core (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic [pic_pkg::op_w-1:0]    op_code,
   input  logic [pic_pkg::porta_w-1:0] port_a_data_in,
   input  logic [pic_pkg::portb_w-1:0] port_b_data_in,
   output logic [pic_pkg::pc_w-1:0]    pc_out,
   output logic                        nop_out,
   output logic                        z,
   output logic [pic_pkg::porta_w-1:0] port_a_tris,
   output logic [pic_pkg::porta_w-1:0] port_a_data_out,
   output logic [pic_pkg::portb_w-1:0] port_b_tris,
   output logic [pic_pkg::portb_w-1:0] port_b_data_out
);
   import pic_pkg::*;

   phase_e      phase;
   pc_action_e  pc_action;
   logic [10:0] jump_target;

   file_bus_if fb_if ();
   pic_alu_if  au_if ();

   pic_sequencer seq_i (
      .clk, .arst_n, .op_code,
      .fb(fb_if), .au(au_if),
      .phase, .pc_action, .jump_target, .nop_out
   );

   pic_alu alu_i (.au(au_if));

   pic_file_regs regs_i (
      .clk, .arst_n, .fb(fb_if),
      .port_a_data_in, .port_b_data_in,
      .port_a_tris, .port_a_data_out, .port_b_tris, .port_b_data_out, .z
   );

   pic_pc_stack pc_i (.clk, .arst_n, .phase, .pc_action, .jump_target, .pc_out);

endmodule

`default_nettype wire

/* tb_pic_model.svh */
// Instruction-level model of the core, stepped once per instruction cycle by the testbench
// Included inside the testbench module, it keeps its own W, STATUS, files, PC and stack
`ifndef TB_PIC_MODEL_SVH
`define TB_PIC_MODEL_SVH

logic [12:0] m_pc;
logic [12:0] m_stack [8];
logic [2:0]  m_sp;
logic [7:0]  m_w;
logic        m_c;
logic        m_dc;
logic        m_z;
logic        m_rp0;
logic [7:0]  m_ram [12:79];
logic [4:0]  m_lat_a;
logic [4:0]  m_tris_a;
logic [7:0]  m_lat_b;
logic [7:0]  m_tris_b;
logic [1:0]  m_sq;                                 // 0 runs, 1 after skip, 2 after branch

task automatic reset_model();
   m_pc     = '0;
   m_sp     = '0;
   m_w      = '0;
   m_c      = 1'b0;
   m_dc     = 1'b0;
   m_z      = 1'b0;
   m_rp0    = 1'b0;
   m_lat_a  = '0;
   m_lat_b  = '0;
   m_tris_a = '1;
   m_tris_b = '1;
   m_sq     = 2'd0;
   foreach (m_ram[i]) m_ram[i] = 8'h00;
   foreach (m_stack[i]) m_stack[i] = 13'h0000;
endtask

// {C, DC, sum}
function automatic logic [9:0] add8(input logic [7:0] a, input logic [7:0] b);
   logic [8:0] s;
   logic [4:0] h;
   s = {1'b0, a} + {1'b0, b};
   h = {1'b0, a[3:0]} + {1'b0, b[3:0]};
   return {s[8], h[4], s[7:0]};
endfunction

// a - b, C and DC mean no borrow
function automatic logic [9:0] sub8(input logic [7:0] a, input logic [7:0] b);
   return {a >= b, a[3:0] >= b[3:0], a - b};
endfunction

function automatic logic [7:0] read_file(input logic [6:0] fa, input logic [4:0] pa,
                                         input logic [7:0] pb);
   logic [7:0] v;
   v = 8'h00;                                     // Unmapped locations
   if (fa == 7'h03) v = {2'b00, m_rp0, 2'b00, m_z, m_dc, m_c};
   else if (fa >= 7'h0C && fa <= 7'h4F) v = m_ram[fa];
   else if (fa == 7'h05 && m_rp0) v = {3'b000, m_tris_a};
   else if (fa == 7'h05) v = {3'b000, (pa & m_tris_a) | (m_lat_a & ~m_tris_a)};
   else if (fa == 7'h06 && m_rp0) v = m_tris_b;
   else if (fa == 7'h06) v = (pb & m_tris_b) | (m_lat_b & ~m_tris_b);
   return v;
endfunction

task automatic write_file(input logic [6:0] fa, input logic [7:0] v);
   if (fa == 7'h03) begin
      m_c   = v[0];
      m_dc  = v[1];
      m_z   = v[2];
      m_rp0 = v[5];
   end else if (fa >= 7'h0C && fa <= 7'h4F) m_ram[fa] = v;
   else if (fa == 7'h05 && !m_rp0) m_lat_a = v[4:0];
   else if (fa == 7'h05) m_tris_a = v[4:0];
   else if (fa == 7'h06 && !m_rp0) m_lat_b = v;
   else if (fa == 7'h06) m_tris_b = v;
endtask

task automatic step_model(input logic [13:0] code, input logic [4:0] pa, input logic [7:0] pb);
   logic [7:0]  f;
   logic [7:0]  r;
   logic        to_f;
   logic        to_w;
   logic        upd_c;
   logic        upd_dc;
   logic        upd_z;
   logic        nc;
   logic        ndc;
   logic        skip;
   logic        branch;
   logic [12:0] next_pc;
   if (m_sq != 2'd0) begin
      if (m_sq == 2'd1) m_pc = m_pc + 13'd1;       // Past the skipped word
      m_sq = 2'd0;
      return;
   end
   f       = read_file(code[6:0], pa, pb);
   r       = 8'h00;
   to_f    = 1'b0;
   to_w    = 1'b0;
   upd_c   = 1'b0;
   upd_dc  = 1'b0;
   upd_z   = 1'b0;
   nc      = 1'b0;
   ndc     = 1'b0;
   skip    = 1'b0;
   branch  = 1'b0;
   next_pc = m_pc + 13'd1;

   if (code[13:12] == 2'b00 && code[11:8] != 4'h0) begin
      to_f = code[7];
      to_w = !code[7];
      case (code[11:8])
         4'h1: r = 8'h00;                          // CLRF, CLRW
         4'h2: {nc, ndc, r} = sub8(f, m_w);
         4'h3: r = f - 8'd1;
         4'h4: r = m_w | f;
         4'h5: r = m_w & f;
         4'h6: r = m_w ^ f;
         4'h7: {nc, ndc, r} = add8(f, m_w);
         4'h8: r = f;
         4'h9: r = ~f;
         4'hA: r = f + 8'd1;
         4'hB: r = f - 8'd1;
         4'hC: {r, nc} = {m_c, f};                 // RRF through carry
         4'hD: {nc, r} = {f, m_c};                 // RLF through carry
         4'hE: r = {f[3:0], f[7:4]};
         default: r = f + 8'd1;
      endcase
      upd_c  = code[11:8] inside {4'h2, 4'h7, 4'hC, 4'hD};
      upd_dc = code[11:8] inside {4'h2, 4'h7};
      upd_z  = !(code[11:8] inside {4'hB, 4'hC, 4'hD, 4'hE, 4'hF});
      skip   = (code[11:8] == 4'hB || code[11:8] == 4'hF) && (r == 8'h00);
   end else begin
      casez (code)
         14'b00_0000_1???_????: begin              // MOVWF
            to_f = 1'b1;
            r    = m_w;
         end
         14'b00_0000_0000_1000: begin              // RETURN
            m_sp    = m_sp - 3'd1;
            next_pc = m_stack[m_sp];
            branch  = 1'b1;
         end
         14'b01_????_????_????: begin
            case (code[11:10])
               2'b00: r = f & ~(8'h01 << code[9:7]);
               2'b01: r = f | (8'h01 << code[9:7]);
               2'b10: skip = !f[code[9:7]];
               default: skip = f[code[9:7]];
            endcase
            to_f = !code[11];
         end
         14'b10_????_????_????: begin              // CALL and GOTO
            if (!code[11]) begin
               m_stack[m_sp] = m_pc + 13'd1;
               m_sp          = m_sp + 3'd1;        // Oldest entry overwritten on wrap
            end
            next_pc = {2'b00, code[10:0]};
            branch  = 1'b1;
         end
         14'b11_01??_????_????: begin              // RETLW
            r       = code[7:0];
            to_w    = 1'b1;
            m_sp    = m_sp - 3'd1;
            next_pc = m_stack[m_sp];
            branch  = 1'b1;
         end
         14'b11_00??_????_????: begin
            r    = code[7:0];
            to_w = 1'b1;
         end
         14'b11_1000_????_????,
         14'b11_1001_????_????,
         14'b11_1010_????_????: begin
            case (code[9:8])
               2'b00: r = m_w | code[7:0];
               2'b01: r = m_w & code[7:0];
               default: r = m_w ^ code[7:0];
            endcase
            to_w  = 1'b1;
            upd_z = 1'b1;
         end
         14'b11_11??_????_????: begin              // SUBLW, ADDLW
            if (code[9]) {nc, ndc, r} = add8(code[7:0], m_w);
            else {nc, ndc, r} = sub8(code[7:0], m_w);
            to_w   = 1'b1;
            upd_c  = 1'b1;
            upd_dc = 1'b1;
            upd_z  = 1'b1;
         end
         default: ;                                // NOP and unsupported codes
      endcase
   end

   // STATUS write first, flag updates take priority
   if (to_f) write_file(code[6:0], r);
   if (to_w) m_w = r;
   if (upd_c) m_c = nc;
   if (upd_dc) m_dc = ndc;
   if (upd_z) m_z = (r == 8'h00);
   m_pc = next_pc;
   if (branch) m_sq = 2'd2;
   else if (skip) m_sq = 2'd1;
endtask

`endif

/* tb_pic16_core.sv */
// Testbench for the PIC16 core with a random program ROM and random port pins
// Outputs are compared with an instruction-level model at every cycle boundary
`default_nettype none

module tb_pic16_core;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int  run_cycles = 3000;
   localparam int  rom_words  = 256;
   localparam time run_limit  = 60000;             // Limit in ns with margin over 3000 cycles

   logic        clk;
   logic        arst_n;
   logic [13:0] op_code;
   logic [4:0]  port_a_data_in;
   logic [7:0]  port_b_data_in;
   logic [12:0] pc_out;
   logic        nop_out;
   logic        z;
   logic [4:0]  port_a_tris;
   logic [4:0]  port_a_data_out;
   logic [7:0]  port_b_tris;
   logic [7:0]  port_b_data_out;
   logic [13:0] rom [rom_words];
   logic [31:0] lcg_state;
   int          mismatches;
   int          failures;

   `include "tb_pic_model.svh"

   pic16_core dut_i (
      .clk, .arst_n, .op_code, .port_a_data_in, .port_b_data_in,
      .pc_out, .nop_out, .z,
      .port_a_tris, .port_a_data_out, .port_b_tris, .port_b_data_out
   );

   always #2 clk = ~clk;

   // ==================================================
   // Random program generation
   // ==================================================
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // STATUS, ports/TRIS or RAM 0x0C..0x1F
   function automatic logic [6:0] pick_file(input logic [7:0] r);
      logic [6:0] fa;
      case (r[2:0])
         3'd0: fa = 7'h03;
         3'd1: fa = 7'h05;
         3'd2: fa = 7'h06;
         default: fa = 7'h0C + 7'(r[7:3] % 5'd20);
      endcase
      return fa;
   endfunction

   function automatic logic [13:0] random_instr();
      logic [31:0] r;
      logic [6:0]  fa;
      logic [5:0]  sel;
      logic [13:0] code;
      r   = lcg_next();
      fa  = pick_file(r[23:16]);
      sel = r[31:26];
      if (sel < 6'd28) begin                                     // Byte ops and MOVWF
         code = {2'b00, r[11:8], r[7] | (r[11:8] == 4'h0), fa};
      end
      else if (sel < 6'd32) code = {7'b0000001, fa};
      else if (sel < 6'd42) code = {2'b01, r[11:7], fa};         // Bit ops
      else if (sel < 6'd56) begin
         code = {2'b11, (r[11:10] == 2'b01) ? 2'b00 : r[11:10], r[9:0]};
         if (code[11:8] == 4'hB) code[8] = 1'b0;                 // No unsupported literal code
      end
      else if (sel < 6'd59) code = {6'b101000, r[7:0]};          // GOTO
      else if (sel < 6'd61) code = {6'b100000, r[7:0]};          // CALL
      else if (sel < 6'd62) code = 14'h0008;
      else if (sel < 6'd63) code = {6'b110100, r[7:0]};          // RETLW
      else code = 14'h0000;
      return code;
   endfunction

   task automatic build_program();
      // Nested calls fill every stack entry with a real address
      for (int i = 0; i < 8; i++) begin
         rom[i] = {3'b100, 11'(i + 1)};
      end
      for (int i = 8; i < rom_words; i++) begin
         rom[i] = random_instr();
      end
   endtask

   // ==================================================
   // Output checks
   // ==================================================
   task automatic compare_out(input string name, input logic [15:0] got,
                              input logic [15:0] exp, input int cyc);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch %s in cycle %0d: dut %h, model %h", name, cyc, got, exp);
      end
   endtask

   task automatic check_outputs(input int cyc);
      compare_out("pc_out", 16'(pc_out), 16'(m_pc), cyc);
      compare_out("nop_out", 16'(nop_out), 16'(m_sq == 2'd0), cyc);
      compare_out("z", 16'(z), 16'(m_z), cyc);
      compare_out("port_a_tris", 16'(port_a_tris), 16'(m_tris_a), cyc);
      compare_out("port_a_data_out", 16'(port_a_data_out), 16'(m_lat_a), cyc);
      compare_out("port_b_tris", 16'(port_b_tris), 16'(m_tris_b), cyc);
      compare_out("port_b_data_out", 16'(port_b_data_out), 16'(m_lat_b), cyc);
   endtask

   initial begin
      int          cycles;
      int          guard;
      logic [31:0] r;
      clk            = 1'b0;
      arst_n         = 1'b0;
      op_code        = 14'h0000;
      port_a_data_in = 5'h00;
      port_b_data_in = 8'h00;
      mismatches     = 0;
      failures       = 0;
      cycles         = 0;
      lcg_state      = 32'hdb39ebf7;
      build_program();
      reset_model();

      for (int i = 0; i < 5; i++) begin
         @(posedge clk);
      end
      @(negedge clk);
      arst_n = 1'b1;                               // Released in Q1 low phase

      guard = 0;
      while ((pc_out !== 13'd0 || nop_out !== 1'b1) && guard < 10) begin
         @(negedge clk);
         guard++;
      end
      if (pc_out !== 13'd0 || nop_out !== 1'b1) begin
         failures++;
         $display("reset values never appeared on pc_out and nop_out");
      end

      // One pass per instruction cycle from the Q1 falling edge
      if (failures == 0) begin
         while (cycles < run_cycles && $time < run_limit) begin
            check_outputs(cycles);
            step_model(rom[m_pc[7:0]], port_a_data_in, port_b_data_in);
            for (int ph = 0; ph < 4; ph++) begin
               op_code = rom[pc_out[7:0]];
               if (ph == 3) begin                  // New pins only in Q4
                  r              = lcg_next();
                  port_a_data_in = r[4:0];
                  port_b_data_in = r[15:8];
               end
               @(negedge clk);
            end
            cycles++;
         end
         if (cycles < run_cycles) begin
            failures++;
            $display("run timed out after %0d of %0d cycles", cycles, run_cycles);
         end else begin
            check_outputs(cycles);
         end
      end

      $display("run ended after %0d cycles: %0d mismatches, %0d other failures",
               cycles, mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
pic_pkg.sv
file_bus_if.sv
pic_alu_if.sv
pic_alu.sv
pic_file_regs.sv
pic_pc_stack.sv
pic_sequencer.sv
pic16_core.sv
tb_pic16_core.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" \
   && verilator --binary --timing -Wno-fatal --top-module tb_pic16_core -f sources.f \
   && ./obj_dir/Vtb_pic16_core | tee /dev/stderr | grep -x "TEST OK" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
